// ==== logic/ccu_pkg.sv ====
package ccu_pkg;

    // ------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------

    // request and memory address
    localparam int unsigned AddrWidth = 32;
    // one data beat
    localparam int unsigned DataWidth = 64;
    // transaction id
    localparam int unsigned IdWidth   = 4;

    // ------------------------------------------------------------
    // line geometry
    // ------------------------------------------------------------

    // beats per cache line
    localparam int unsigned LineWords       = 2;
    // address bit picking the critical word
    localparam int unsigned WordOffsetBit   = 3;
    // word index within a line
    localparam int unsigned LineIdxWidth    = $clog2(LineWords);
    // low address bits covered by one line
    localparam int unsigned LineOffsetWidth = WordOffsetBit + LineIdxWidth;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;
    typedef logic [IdWidth-1:0]   id_t;

    // word 0 sits at the lowest address of the line
    typedef data_t [LineWords-1:0] line_t;

    // ------------------------------------------------------------
    // snoop response flags
    // ------------------------------------------------------------

    typedef struct packed {
        logic data_transfer;
        logic error;
        logic is_shared;
        logic pass_dirty;
    } snoop_resp_t;

endpackage

// ==== logic/ccu_ifs.sv ====
// read request from the holding buffer to the snoop FSM
interface ccu_req_if import ccu_pkg::*; ();

    logic  valid;
    logic  ready;
    addr_t addr;
    id_t   id;
    // high for a full line read, low for one word
    logic  whole_line;

    modport intake (
        output valid, addr, id, whole_line,
        input  ready
    );

    modport ctrl (
        input  valid, addr, id, whole_line,
        output ready
    );

endinterface

// snoop outcome handed to the return side
interface ccu_result_if import ccu_pkg::*; ();

    logic  valid;
    logic  ready;
    logic  hit;
    // only meaningful with hit
    line_t line;
    logic  shared;
    logic  dirty;
    addr_t addr;
    id_t   id;
    logic  whole_line;

    modport ctrl (
        output valid, hit, line, shared, dirty, addr, id, whole_line,
        input  ready
    );

    modport ret (
        input  valid, hit, line, shared, dirty, addr, id, whole_line,
        output ready
    );

endinterface

// ==== logic/ccu_req_intake.sv ====
module ccu_req_intake import ccu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  addr_t    req_addr_i,
    input  id_t      req_id_i,
    input  logic     req_line_i,
    ccu_req_if.intake req
);

    logic  full_q;
    logic  full_d;
    logic  ready_q;
    logic  accept;
    logic  release_buf;

    addr_t addr_q;
    id_t   id_q;
    logic  line_q;

    assign accept      = req_valid_i & req_ready_o;
    assign release_buf = req.valid & req.ready;

    // ready comes from a flop so it stays low for the first cycle
    assign req_ready_o = ready_q;

    // held request towards the snoop side
    assign req.valid      = full_q;
    assign req.addr       = addr_q;
    assign req.id         = id_q;
    assign req.whole_line = line_q;

    // accept only when empty, release only when full
    always_comb begin : next_fill
        full_d = full_q;
        if (release_buf) begin
            full_d = 1'b0;
        end
        if (accept) begin
            full_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : fill_state
        if (!rst_ni) begin
            full_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            full_q  <= full_d;
            ready_q <= !full_d;
        end
    end

    always_ff @(posedge clk_i) begin : hold_request
        if (accept) begin
            addr_q <= req_addr_i;
            id_q   <= req_id_i;
            line_q <= req_line_i;
        end
    end

endmodule

// ==== logic/ccu_snoop_ctrl.sv ====
module ccu_snoop_ctrl import ccu_pkg::*; #(
    parameter int unsigned NumSnoop     = 4,
    parameter int unsigned InitiatorIdx = 0
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    ccu_req_if.ctrl                    req,
    ccu_result_if.ctrl                 res,
    output logic        [NumSnoop-1:0] ac_valid_o,
    input  logic        [NumSnoop-1:0] ac_ready_i,
    output addr_t                      ac_addr_o,
    input  logic        [NumSnoop-1:0] cr_valid_i,
    output logic        [NumSnoop-1:0] cr_ready_o,
    input  snoop_resp_t [NumSnoop-1:0] cr_resp_i,
    input  logic        [NumSnoop-1:0] cd_valid_i,
    output logic        [NumSnoop-1:0] cd_ready_o,
    input  data_t       [NumSnoop-1:0] cd_data_i,
    input  logic        [NumSnoop-1:0] cd_last_i
);

    localparam int unsigned PortIdxWidth = (NumSnoop > 1) ? $clog2(NumSnoop) : 1;
    // requester port counts as already snooped
    localparam logic [NumSnoop-1:0] SelfMask = NumSnoop'(1) << InitiatorIdx;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SNOOP_REQ,
        ST_SNOOP_RESP,
        ST_SNOOP_DATA,
        ST_HANDOFF
    } snoop_state_e;

    snoop_state_e state_q, state_d;

    logic req_fire;
    logic capture;
    logic [NumSnoop-1:0] ac_fire, cr_fire, cd_fire;
    logic [NumSnoop-1:0] ac_done_q, cr_done_q, cd_done_q;
    // latched response flags per port
    logic [NumSnoop-1:0] has_data_q, error_q, shared_q, dirty_q;
    logic [NumSnoop-1:0] offer;
    logic [PortIdxWidth-1:0] first_idx;
    logic [LineIdxWidth-1:0] beat_q;

    addr_t addr_q;
    id_t   id_q;
    logic  line_req_q;
    line_t line_q;

    assign req_fire = req.valid & req.ready;
    assign ac_fire  = ac_valid_o & ac_ready_i;
    assign cr_fire  = cr_valid_i & cr_ready_o;
    assign cd_fire  = cd_valid_i & cd_ready_o;

    // errored data is drained but never used
    assign offer   = has_data_q & ~error_q;
    assign capture = (|offer) & cd_fire[first_idx];

    // lowest index with clean data wins
    always_comb begin : pick_first
        first_idx = '0;
        for (int i = NumSnoop - 1; i >= 0; i--) begin
            if (offer[i]) begin
                first_idx = PortIdxWidth'(i);
            end
        end
    end

    // ------------------------------------------------------------
    // channel handshakes
    // ------------------------------------------------------------

    assign req.ready  = (state_q == ST_IDLE);
    assign ac_addr_o  = addr_q;
    assign ac_valid_o = (state_q == ST_SNOOP_REQ)  ? ~ac_done_q : '0;
    assign cr_ready_o = (state_q == ST_SNOOP_RESP) ? ~cr_done_q : '0;
    assign cd_ready_o = (state_q == ST_SNOOP_DATA) ? (has_data_q & ~cd_done_q) : '0;

    assign res.valid      = (state_q == ST_HANDOFF);
    assign res.hit        = |offer;
    assign res.line       = line_q;
    assign res.shared     = |shared_q;
    assign res.dirty      = |dirty_q;
    assign res.addr       = addr_q;
    assign res.id         = id_q;
    assign res.whole_line = line_req_q;

    always_comb begin : next_state
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (req_fire) begin
                    state_d = ST_SNOOP_REQ;
                end
            end
            ST_SNOOP_REQ: begin
                if ((ac_done_q | ac_fire) == '1) begin
                    state_d = ST_SNOOP_RESP;
                end
            end
            ST_SNOOP_RESP: begin
                if ((cr_done_q | cr_fire) == '1) begin
                    state_d = ST_SNOOP_DATA;
                end
            end
            // passes straight through when nobody offered data
            ST_SNOOP_DATA: begin
                if ((has_data_q & ~(cd_done_q | (cd_fire & cd_last_i))) == '0) begin
                    state_d = ST_HANDOFF;
                end
            end
            ST_HANDOFF: begin
                if (res.ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            state_q    <= ST_IDLE;
            ac_done_q  <= '0;
            cr_done_q  <= '0;
            cd_done_q  <= '0;
            has_data_q <= '0;
            error_q    <= '0;
            shared_q   <= '0;
            dirty_q    <= '0;
            beat_q     <= '0;
        end else begin
            state_q <= state_d;
            if (req_fire) begin
                ac_done_q  <= SelfMask;
                cr_done_q  <= SelfMask;
                cd_done_q  <= '0;
                has_data_q <= '0;
                error_q    <= '0;
                shared_q   <= '0;
                dirty_q    <= '0;
                beat_q     <= '0;
            end else begin
                ac_done_q <= ac_done_q | ac_fire;
                cr_done_q <= cr_done_q | cr_fire;
                cd_done_q <= cd_done_q | (cd_fire & cd_last_i);
                for (int i = 0; i < NumSnoop; i++) begin
                    if (cr_fire[i]) begin
                        has_data_q[i] <= cr_resp_i[i].data_transfer;
                        error_q[i]    <= cr_resp_i[i].error;
                        shared_q[i]   <= cr_resp_i[i].is_shared;
                        dirty_q[i]    <= cr_resp_i[i].pass_dirty;
                    end
                end
                if (capture) begin
                    beat_q <= beat_q + 1'b1;
                end
            end
        end
    end

    // request fields and captured line
    always_ff @(posedge clk_i) begin : payload_regs
        if (req_fire) begin
            addr_q     <= req.addr;
            id_q       <= req.id;
            line_req_q <= req.whole_line;
        end
        if (capture) begin
            line_q[beat_q] <= cd_data_i[first_idx];
        end
    end

endmodule

// ==== logic/ccu_read_return.sv ====
module ccu_read_return import ccu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    ccu_result_if.ret   res,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    output data_t       rsp_data_o,
    output id_t         rsp_id_o,
    output logic        rsp_last_o,
    output logic        rsp_shared_o,
    output logic        rsp_dirty_o,
    output logic        mem_ar_valid_o,
    input  logic        mem_ar_ready_i,
    output addr_t       mem_ar_addr_o,
    output logic [7:0]  mem_ar_len_o,
    input  logic        mem_r_valid_i,
    output logic        mem_r_ready_o,
    input  data_t       mem_r_data_i,
    input  logic        mem_r_last_i
);

    typedef enum logic [1:0] {
        RR_IDLE,
        RR_SNOOP_BEATS,
        RR_MEM_ADDR,
        RR_MEM_DATA
    } return_state_e;

    return_state_e state_q, state_d;

    logic [LineIdxWidth-1:0] beat_q;
    logic [LineIdxWidth-1:0] crit_idx;
    logic rsp_fire;
    logic rsp_done;

    assign crit_idx = res.addr[WordOffsetBit +: LineIdxWidth];
    assign rsp_fire = rsp_valid_o & rsp_ready_i;
    assign rsp_done = rsp_fire & rsp_last_o;

    // result stays valid and stable until the final beat goes out
    assign res.ready = rsp_done;

    assign rsp_id_o     = res.id;
    assign rsp_shared_o = res.shared;
    assign rsp_dirty_o  = res.dirty;

    // line reads start at the line boundary
    assign mem_ar_addr_o = res.whole_line
        ? {res.addr[AddrWidth-1:LineOffsetWidth], {LineOffsetWidth{1'b0}}}
        : res.addr;
    assign mem_ar_len_o  = res.whole_line ? 8'(LineWords - 1) : 8'd0;

    // ------------------------------------------------------------
    // response mux
    // ------------------------------------------------------------

    always_comb begin : drive_outputs
        rsp_valid_o    = 1'b0;
        rsp_data_o     = res.line[beat_q];
        rsp_last_o     = 1'b0;
        mem_ar_valid_o = 1'b0;
        mem_r_ready_o  = 1'b0;
        unique case (state_q)
            RR_SNOOP_BEATS: begin
                rsp_valid_o = 1'b1;
                if (res.whole_line) begin
                    rsp_data_o = res.line[beat_q];
                    rsp_last_o = (beat_q == LineIdxWidth'(LineWords - 1));
                end else begin
                    // critical word only
                    rsp_data_o = res.line[crit_idx];
                    rsp_last_o = 1'b1;
                end
            end
            RR_MEM_ADDR: begin
                mem_ar_valid_o = 1'b1;
            end
            // memory beats pass straight through
            RR_MEM_DATA: begin
                rsp_valid_o   = mem_r_valid_i;
                mem_r_ready_o = rsp_ready_i;
                rsp_data_o    = mem_r_data_i;
                rsp_last_o    = mem_r_last_i;
            end
            default: ;
        endcase
    end

    always_comb begin : next_state
        state_d = state_q;
        unique case (state_q)
            RR_IDLE: begin
                if (res.valid) begin
                    state_d = res.hit ? RR_SNOOP_BEATS : RR_MEM_ADDR;
                end
            end
            RR_SNOOP_BEATS, RR_MEM_DATA: begin
                if (rsp_done) begin
                    state_d = RR_IDLE;
                end
            end
            RR_MEM_ADDR: begin
                if (mem_ar_ready_i) begin
                    state_d = RR_MEM_DATA;
                end
            end
            default: state_d = RR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : ret_regs
        if (!rst_ni) begin
            state_q <= RR_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == RR_SNOOP_BEATS && rsp_fire) begin
                beat_q <= rsp_last_o ? '0 : beat_q + 1'b1;
            end
        end
    end

endmodule

// ==== logic/ccu_top.sv ====
module ccu_top import ccu_pkg::*; #(
    parameter int unsigned NumSnoop     = 4,
    parameter int unsigned InitiatorIdx = 0
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // request in
    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    input  addr_t                      req_addr_i,
    input  id_t                        req_id_i,
    input  logic                       req_line_i,
    // response out
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,
    output data_t                      rsp_data_o,
    output id_t                        rsp_id_o,
    output logic                       rsp_last_o,
    output logic                       rsp_shared_o,
    output logic                       rsp_dirty_o,
    // snooped caches
    output logic        [NumSnoop-1:0] ac_valid_o,
    input  logic        [NumSnoop-1:0] ac_ready_i,
    output addr_t                      ac_addr_o,
    input  logic        [NumSnoop-1:0] cr_valid_i,
    output logic        [NumSnoop-1:0] cr_ready_o,
    input  snoop_resp_t [NumSnoop-1:0] cr_resp_i,
    input  logic        [NumSnoop-1:0] cd_valid_i,
    output logic        [NumSnoop-1:0] cd_ready_o,
    input  data_t       [NumSnoop-1:0] cd_data_i,
    input  logic        [NumSnoop-1:0] cd_last_i,
    // memory read
    output logic                       mem_ar_valid_o,
    input  logic                       mem_ar_ready_i,
    output addr_t                      mem_ar_addr_o,
    output logic [7:0]                 mem_ar_len_o,
    input  logic                       mem_r_valid_i,
    output logic                       mem_r_ready_o,
    input  data_t                      mem_r_data_i,
    input  logic                       mem_r_last_i
);

    ccu_req_if    u_req_if ();
    ccu_result_if u_res_if ();

    ccu_req_intake u_req_intake (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_id_i    (req_id_i),
        .req_line_i  (req_line_i),
        .req         (u_req_if.intake)
    );

    ccu_snoop_ctrl #(
        .NumSnoop     (NumSnoop),
        .InitiatorIdx (InitiatorIdx)
    ) u_snoop_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req        (u_req_if.ctrl),
        .res        (u_res_if.ctrl),
        .ac_valid_o (ac_valid_o),
        .ac_ready_i (ac_ready_i),
        .ac_addr_o  (ac_addr_o),
        .cr_valid_i (cr_valid_i),
        .cr_ready_o (cr_ready_o),
        .cr_resp_i  (cr_resp_i),
        .cd_valid_i (cd_valid_i),
        .cd_ready_o (cd_ready_o),
        .cd_data_i  (cd_data_i),
        .cd_last_i  (cd_last_i)
    );

    ccu_read_return u_read_return (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .res            (u_res_if.ret),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_data_o     (rsp_data_o),
        .rsp_id_o       (rsp_id_o),
        .rsp_last_o     (rsp_last_o),
        .rsp_shared_o   (rsp_shared_o),
        .rsp_dirty_o    (rsp_dirty_o),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .mem_ar_len_o   (mem_ar_len_o),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_ready_o  (mem_r_ready_o),
        .mem_r_data_i   (mem_r_data_i),
        .mem_r_last_i   (mem_r_last_i)
    );

endmodule

// ==== tests/ccu_agents.sv ====
// snooped cache model, one instance per port
module ccu_snoop_agent import ccu_pkg::*; (
    input  logic        clk_i,
    input  logic        ac_valid_i,
    output logic        ac_ready_o,
    output logic        cr_valid_o,
    input  logic        cr_ready_i,
    output snoop_resp_t cr_resp_o,
    output logic        cd_valid_o,
    input  logic        cd_ready_i,
    output data_t       cd_data_o,
    output logic        cd_last_o,
    // answer for the request in flight
    input  snoop_resp_t resp_i,
    input  line_t       line_i
);

    initial begin : answer_snoops
        ac_ready_o = 1'b0;
        cr_valid_o = 1'b0;
        cr_resp_o  = '0;
        cd_valid_o = 1'b0;
        cd_data_o  = '0;
        cd_last_o  = 1'b0;
        forever begin
            @(posedge clk_i);
            if (ac_valid_i) begin
                // accept the snoop after a short random wait
                repeat ($urandom_range(2, 0)) @(posedge clk_i);
                @(negedge clk_i);
                ac_ready_o = 1'b1;
                @(posedge clk_i);
                @(negedge clk_i);
                ac_ready_o = 1'b0;

                repeat ($urandom_range(3, 0)) @(negedge clk_i);
                cr_valid_o = 1'b1;
                cr_resp_o  = resp_i;
                @(posedge clk_i);
                while (!cr_ready_i) @(posedge clk_i);
                @(negedge clk_i);
                cr_valid_o = 1'b0;

                // data beats only when the response promised them
                if (resp_i.data_transfer) begin
                    for (int w = 0; w < LineWords; w++) begin
                        cd_valid_o = 1'b1;
                        cd_data_o  = line_i[w];
                        cd_last_o  = (w == LineWords - 1);
                        @(posedge clk_i);
                        while (!cd_ready_i) @(posedge clk_i);
                        @(negedge clk_i);
                    end
                    cd_valid_o = 1'b0;
                    cd_last_o  = 1'b0;
                end
            end
        end
    end

endmodule

// memory model, every word is made from its own address
module ccu_mem_agent import ccu_pkg::*; (
    input  logic       clk_i,
    input  logic       ar_valid_i,
    output logic       ar_ready_o,
    input  addr_t      ar_addr_i,
    input  logic [7:0] ar_len_i,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output data_t      r_data_o,
    output logic       r_last_o
);

    function automatic data_t word_at(input addr_t a);
        return {a ^ 32'h9e37_79b9, a};
    endfunction

    initial begin : serve_reads
        addr_t      addr;
        logic [7:0] len;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_last_o   = 1'b0;
        forever begin
            @(posedge clk_i);
            if (ar_valid_i) begin
                repeat ($urandom_range(2, 0)) @(posedge clk_i);
                @(negedge clk_i);
                ar_ready_o = 1'b1;
                @(posedge clk_i);
                addr = ar_addr_i;
                len  = ar_len_i;
                @(negedge clk_i);
                ar_ready_o = 1'b0;
                for (int b = 0; b <= len; b++) begin
                    r_valid_o = 1'b1;
                    r_data_o  = word_at(addr + addr_t'(b * (DataWidth / 8)));
                    r_last_o  = (b == len);
                    @(posedge clk_i);
                    while (!r_ready_i) @(posedge clk_i);
                    @(negedge clk_i);
                end
                r_valid_o = 1'b0;
                r_last_o  = 1'b0;
            end
        end
    end

endmodule

// ==== tests/ccu_tb.sv ====
module ccu_tb import ccu_pkg::*; ();

    localparam int unsigned NumSnoop      = 4;
    localparam int unsigned InitiatorIdx  = 0;
    localparam int          NumRows       = 8;
    localparam int          ResetCycles   = 3;
    localparam int          TimeoutCycles = NumRows * 80 + ResetCycles;
    localparam logic [31:0] Seed          = 32'h1e7a;

    typedef struct packed {
        addr_t                      addr;
        id_t                        id;
        logic                       whole_line;
        snoop_resp_t [NumSnoop-1:0] resp;
        data_t                      base;
    } row_t;

    logic clk = 1'b0;
    logic rst_n;
    int   cycles = 0;
    row_t rows [NumRows];

    logic  req_valid, req_ready, req_line;
    addr_t req_addr;
    id_t   req_id;
    // address of the request being snooped
    addr_t cur_addr;
    logic  rsp_valid, rsp_ready, rsp_last, rsp_shared, rsp_dirty;
    data_t rsp_data;
    id_t   rsp_id;

    logic [NumSnoop-1:0]        ac_valid, cr_ready, cd_ready;
    addr_t                      ac_addr;
    wire  [NumSnoop-1:0]        ac_ready, cr_valid, cd_valid, cd_last;
    wire snoop_resp_t [NumSnoop-1:0] cr_resp;
    wire data_t [NumSnoop-1:0]  cd_data;
    snoop_resp_t [NumSnoop-1:0] port_resp;
    line_t [NumSnoop-1:0]       port_line;

    logic       mem_ar_valid, mem_r_ready;
    addr_t      mem_ar_addr;
    logic [7:0] mem_ar_len;
    wire        mem_ar_ready, mem_r_valid, mem_r_last;
    wire data_t mem_r_data;

    always #10 clk = ~clk;

    ccu_top #(
        .NumSnoop     (NumSnoop),
        .InitiatorIdx (InitiatorIdx)
    ) u_ccu_top (
        .clk_i (clk), .rst_ni (rst_n),
        .req_valid_i (req_valid), .req_ready_o (req_ready), .req_addr_i (req_addr),
        .req_id_i (req_id), .req_line_i (req_line),
        .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_data_o (rsp_data),
        .rsp_id_o (rsp_id), .rsp_last_o (rsp_last), .rsp_shared_o (rsp_shared),
        .rsp_dirty_o (rsp_dirty),
        .ac_valid_o (ac_valid), .ac_ready_i (ac_ready), .ac_addr_o (ac_addr),
        .cr_valid_i (cr_valid), .cr_ready_o (cr_ready), .cr_resp_i (cr_resp),
        .cd_valid_i (cd_valid), .cd_ready_o (cd_ready), .cd_data_i (cd_data),
        .cd_last_i (cd_last),
        .mem_ar_valid_o (mem_ar_valid), .mem_ar_ready_i (mem_ar_ready),
        .mem_ar_addr_o (mem_ar_addr), .mem_ar_len_o (mem_ar_len),
        .mem_r_valid_i (mem_r_valid), .mem_r_ready_o (mem_r_ready),
        .mem_r_data_i (mem_r_data), .mem_r_last_i (mem_r_last)
    );

    for (genvar p = 0; p < NumSnoop; p++) begin : g_snoop
        ccu_snoop_agent u_snoop_agent (
            .clk_i (clk), .ac_valid_i (ac_valid[p]), .ac_ready_o (ac_ready[p]),
            .cr_valid_o (cr_valid[p]), .cr_ready_i (cr_ready[p]), .cr_resp_o (cr_resp[p]),
            .cd_valid_o (cd_valid[p]), .cd_ready_i (cd_ready[p]), .cd_data_o (cd_data[p]),
            .cd_last_o (cd_last[p]), .resp_i (port_resp[p]), .line_i (port_line[p])
        );
    end

    ccu_mem_agent u_mem_agent (
        .clk_i (clk), .ar_valid_i (mem_ar_valid), .ar_ready_o (mem_ar_ready),
        .ar_addr_i (mem_ar_addr), .ar_len_i (mem_ar_len), .r_valid_o (mem_r_valid),
        .r_ready_i (mem_r_ready), .r_data_o (mem_r_data), .r_last_o (mem_r_last)
    );

    // ------------------------------------------------------------
    // reference values
    // ------------------------------------------------------------

    function automatic data_t mem_word(input addr_t a);
        return {a ^ 32'h9e37_79b9, a};
    endfunction

    // word w of the line held by cache port p
    function automatic data_t cache_word(input data_t base, input int p, input int w);
        return base ^ data_t'((p << 4) | w);
    endfunction

    function automatic row_t make_row(input addr_t a, input id_t i, input logic w,
                                      input logic [4*NumSnoop-1:0] r, input data_t b);
        row_t row;
        row.addr       = a;
        row.id         = i;
        row.whole_line = w;
        row.resp       = r;
        row.base       = b;
        return row;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else stop_run($sformatf("MISMATCH at %0t: %s got %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic run_row(input int r);
        row_t  row;
        int    first;
        int    nbeats;
        int    beat;
        logic  exp_shared;
        logic  exp_dirty;
        addr_t line_base;
        data_t exp_data [LineWords];
        row        = rows[r];
        first      = -1;
        exp_shared = 1'b0;
        exp_dirty  = 1'b0;
        for (int p = 0; p < NumSnoop; p++) begin
            if (p != InitiatorIdx) begin
                exp_shared = exp_shared | row.resp[p].is_shared;
                exp_dirty  = exp_dirty | row.resp[p].pass_dirty;
                if (first < 0 && row.resp[p].data_transfer && !row.resp[p].error) begin
                    first = p;
                end
            end
        end
        nbeats    = row.whole_line ? LineWords : 1;
        line_base = row.addr & ~addr_t'(LineWords * DataWidth / 8 - 1);
        for (int b = 0; b < LineWords; b++) begin
            if (first >= 0) begin
                exp_data[b] = row.whole_line ? cache_word(row.base, first, b)
                            : cache_word(row.base, first, row.addr[WordOffsetBit]);
            end else begin
                exp_data[b] = row.whole_line ? mem_word(line_base + addr_t'(b * DataWidth / 8))
                            : mem_word(row.addr);
            end
        end

        @(negedge clk);
        for (int p = 0; p < NumSnoop; p++) begin
            port_resp[p] = row.resp[p];
            for (int w = 0; w < LineWords; w++) begin
                port_line[p][w] = cache_word(row.base, p, w);
            end
        end
        rsp_ready = 1'b0;
        cur_addr  = row.addr;
        req_valid = 1'b1;
        req_addr  = row.addr;
        req_id    = row.id;
        req_line  = row.whole_line;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;

        // beats under random back-pressure
        beat = 0;
        while (beat < nbeats) begin
            @(negedge clk);
            rsp_ready = ($urandom_range(3, 0) != 0);
            @(posedge clk);
            if (rsp_valid && rsp_ready) begin
                check_field("rsp_data_o", rsp_data, exp_data[beat]);
                check_field("rsp_id_o", 64'(rsp_id), 64'(row.id));
                check_field("rsp_last_o", 64'(rsp_last), 64'(beat == nbeats - 1));
                check_field("rsp_shared_o", 64'(rsp_shared), 64'(exp_shared));
                check_field("rsp_dirty_o", 64'(rsp_dirty), 64'(exp_dirty));
                beat++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    initial begin : run_tests
        void'($urandom(Seed));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_id    = '0;
        req_line  = 1'b0;
        cur_addr  = '0;
        rsp_ready = 1'b0;
        port_resp = '0;
        port_line = '0;
        // resp nibbles are ports 3..0, each {data, error, shared, dirty}
        rows[0] = make_row(32'h0000_1008, 4'h1, 1'b0, 16'h0200, 64'h1111_0000_0000_0000);
        rows[1] = make_row(32'h0000_2010, 4'h2, 1'b1, 16'h8a80, 64'h2222_0000_0000_0000);
        rows[2] = make_row(32'h0000_3018, 4'h3, 1'b0, 16'h0090, 64'h3333_0000_0000_0000);
        // error is the only offer, memory answers
        rows[3] = make_row(32'h0000_4020, 4'h4, 1'b1, 16'h2c00, 64'h4444_0000_0000_0000);
        rows[4] = make_row(32'h0000_5000, 4'h5, 1'b1, 16'h81c0, 64'h5555_0000_0000_0000);
        rows[5] = make_row(32'h0000_6000, 4'h6, 1'b0, 16'h0800, 64'h6666_0000_0000_0000);
        // flags at the requester port never count
        rows[6] = make_row(32'h0000_7018, 4'h7, 1'b1, 16'h1003, 64'h7777_0000_0000_0000);
        rows[7] = make_row(32'h0000_8008, 4'h8, 1'b1, 16'h0808, 64'h8888_0000_0000_0000);
        repeat (ResetCycles) @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < NumRows; r++) begin
            run_row(r);
        end
        @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    // no snoop may reach the requester
    always @(posedge clk) begin : watch_requester_port
        if (rst_n) begin
            assert (!ac_valid[InitiatorIdx])
            else stop_run("a snoop was sent to the requester's own port");
        end
    end

    // every accepted snoop carries the request address
    always @(posedge clk) begin : watch_snoop_addr
        if (rst_n && ((ac_valid & ac_ready) != '0)) begin
            check_field("ac_addr_o", 64'(ac_addr), 64'(cur_addr));
        end
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            stop_run("timeout: the responses did not finish within the cycle limit");
        end
    end

endmodule

// ==== compile.f ====
logic/ccu_pkg.sv
logic/ccu_ifs.sv
logic/ccu_req_intake.sv
logic/ccu_snoop_ctrl.sv
logic/ccu_read_return.sv
logic/ccu_top.sv
tests/ccu_agents.sv
tests/ccu_tb.sv
